// ==== common/oramPkg.sv ====
// ----------------------------------------
// ORAM backend package
// Tree geometry, DRAM port widths, codes
// ----------------------------------------
package oramPkg;

	// ----------------------------------------
	// Tree geometry
	// ----------------------------------------

	// Leaf bits, tree has OramL+1 levels
	localparam int OramL = 3;
	localparam int NumLevels = OramL + 1;
	localparam int NumBuckets = (1 << NumLevels) - 1;

	// DRAM words per bucket
	localparam int BucketBursts = 2;
	localparam int TreeWords = NumBuckets * BucketBursts;
	localparam int PathWords = NumLevels * BucketBursts;

	// Counter widths
	localparam int InitCntWidth = $clog2(TreeWords + 1);
	localparam int LevelWidth = (NumLevels > 1) ? $clog2(NumLevels) : 1;
	localparam int BurstWidth = (BucketBursts > 1) ? $clog2(BucketBursts) : 1;

	// ----------------------------------------
	// DRAM port
	// ----------------------------------------

	localparam int DdrAWidth = 16;
	localparam int DdrDWidth = 64;
	localparam int DdrMWidth = 8;
	localparam int DdrCWidth = 3;

	// Frontend command width
	localparam int BeCmdWidth = 1;

	typedef logic [OramL-1:0] leafT;
	typedef logic [3:0] bucketT;
	typedef logic [DdrAWidth-1:0] ddrAddrT;
	typedef logic [DdrDWidth-1:0] ddrDataT;
	typedef logic [DdrMWidth-1:0] ddrMaskT;
	typedef logic [DdrCWidth-1:0] ddrCmdT;
	typedef logic [BeCmdWidth-1:0] beCmdT;

	// DRAM command codes
	localparam ddrCmdT DdrCmdWrite = 3'd0;
	localparam ddrCmdT DdrCmdRead = 3'd1;

	// Frontend command codes
	localparam beCmdT BeCmdReadPath = 1'b0;
	localparam beCmdT BeCmdWritePath = 1'b1;

	// Backend control FSM
	typedef enum logic {
		StInitialize,
		StNormal
	} backendStateT;

endpackage

// ==== hw/addrGen/pathAddrGen.sv ====
// ----------------------------------------
// Path address generator
// One DRAM command per word, root to leaf
// ----------------------------------------
`timescale 1ns/10ps

module pathAddrGen import oramPkg::*; (
	input  logic    Clock,
	input  logic    rstN,

	// Held idle until initialization ends
	input  logic    Normal,

	// Frontend command
	input  beCmdT   InCommand,
	input  leafT    InLeaf,
	input  logic    InCommandValid,
	output logic    InCommandReady,

	// DRAM command
	output ddrAddrT GenCommandAddress,
	output ddrCmdT  GenCommand,
	output logic    GenCommandValid,
	input  logic    GenCommandReady
);

	// ----------------------------------------
	// Path walk state
	// ----------------------------------------

	logic                  busy;
	leafT                  leafQ;
	ddrCmdT                cmdQ;
	logic [LevelWidth-1:0] level;
	logic [BurstWidth-1:0] burst;

	logic                  accept;
	logic                  issue;
	logic                  lastBurst;
	logic                  lastLevel;

	// Bucket index pieces
	bucketT                levelBase;
	bucketT                leafPart;
	bucketT                bucket;

	assign accept = InCommandValid & InCommandReady;
	assign issue = GenCommandValid & GenCommandReady;

	assign lastBurst = (burst == BurstWidth'(BucketBursts - 1));
	assign lastLevel = (level == LevelWidth'(NumLevels - 1));

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			level <= '0;
			burst <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			level <= '0;
			burst <= '0;
		end else if (issue) begin
			if (lastBurst) begin
				burst <= '0;
				// Leaf bucket done, path complete
				if (lastLevel) begin
					busy <= 1'b0;
				end else begin
					level <= level + 1'b1;
				end
			end else begin
				burst <= burst + 1'b1;
			end
		end
	end

	// Leaf and code kept for the whole path
	always_ff @(posedge Clock) begin
		if (accept) begin
			leafQ <= InLeaf;
			cmdQ <= (InCommand == BeCmdWritePath) ? DdrCmdWrite : DdrCmdRead;
		end
	end

	// ----------------------------------------
	// Address
	// ----------------------------------------

	// First bucket of level d is 2^d - 1
	assign levelBase = (bucketT'(1) << level) - bucketT'(1);
	// Top d bits of the leaf pick the bucket on that level
	assign leafPart = bucketT'(leafQ) >> (OramL - int'(level));
	assign bucket = levelBase + leafPart;

	assign GenCommandAddress = ddrAddrT'(bucket) * ddrAddrT'(BucketBursts)
		+ ddrAddrT'(burst);
	assign GenCommand = cmdQ;
	assign GenCommandValid = busy;

	// Accept a new path only when idle
	assign InCommandReady = Normal & ~busy;

endmodule

// ==== hw/backend/backendControl.sv ====
// ----------------------------------------
// Backend control
// Init/Normal FSM and DRAM port muxing
// ----------------------------------------
`timescale 1ns/10ps

module backendControl import oramPkg::*; (
	input  logic    Clock,
	input  logic    rstN,

	input  logic    InitDone,
	output logic    Normal,

	// Initializer side
	input  ddrAddrT InitCommandAddress,
	input  logic    InitCommandValid,
	output logic    InitCommandReady,
	input  ddrDataT InitWriteData,
	input  ddrMaskT InitWriteMask,
	input  logic    InitWriteDataValid,
	output logic    InitWriteDataReady,

	// Address generator side
	input  ddrAddrT GenCommandAddress,
	input  ddrCmdT  GenCommand,
	input  logic    GenCommandValid,
	output logic    GenCommandReady,

	// Frontend write data
	input  ddrDataT LoadData,
	input  logic    LoadValid,
	output logic    LoadReady,

	// DRAM ports
	output ddrAddrT DRAMCommandAddress,
	output ddrCmdT  DRAMCommand,
	output logic    DRAMCommandValid,
	input  logic    DRAMCommandReady,
	output ddrDataT DRAMWriteData,
	output ddrMaskT DRAMWriteMask,
	output logic    DRAMWriteDataValid,
	input  logic    DRAMWriteDataReady
);

	// ----------------------------------------
	// State machine
	// ----------------------------------------

	backendStateT state;
	backendStateT nextState;
	logic         initializing;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= StInitialize;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			// Leave once the tree is zeroed
			StInitialize: if (InitDone) nextState = StNormal;
			default: nextState = state;
		endcase
	end

	assign initializing = (state == StInitialize);
	assign Normal = (state == StNormal);

	// ----------------------------------------
	// Port muxing
	// ----------------------------------------

	// Command port, initializer only writes
	assign DRAMCommandAddress = initializing ? InitCommandAddress : GenCommandAddress;
	assign DRAMCommand = initializing ? DdrCmdWrite : GenCommand;
	assign DRAMCommandValid = initializing ? InitCommandValid : GenCommandValid;

	// Write data, Load stream passes straight through in Normal
	assign DRAMWriteData = initializing ? InitWriteData : LoadData;
	assign DRAMWriteMask = initializing ? InitWriteMask : '0;
	assign DRAMWriteDataValid = initializing ? InitWriteDataValid : LoadValid;

	// Inactive source never sees ready
	assign InitCommandReady = DRAMCommandReady & initializing;
	assign GenCommandReady = DRAMCommandReady & Normal;
	assign InitWriteDataReady = DRAMWriteDataReady & initializing;
	assign LoadReady = DRAMWriteDataReady & Normal;

endmodule

// ==== hw/backend/pathOramBackend.sv ====
// ----------------------------------------
// Path ORAM backend top
// Tree init and path address generation
// ----------------------------------------
`timescale 1ns/10ps

module pathOramBackend import oramPkg::*; (
	input  logic    Clock,
	input  logic    rstN,

	// Frontend
	input  beCmdT   InCommand,
	input  leafT    InLeaf,
	input  logic    InCommandValid,
	output logic    InCommandReady,
	input  ddrDataT LoadData,
	input  logic    LoadValid,
	output logic    LoadReady,

	// DRAM
	output ddrAddrT DRAMCommandAddress,
	output ddrCmdT  DRAMCommand,
	output logic    DRAMCommandValid,
	input  logic    DRAMCommandReady,
	// Read return is not consumed yet
	input  ddrDataT DRAMReadData,
	input  logic    DRAMReadDataValid,
	output ddrDataT DRAMWriteData,
	output ddrMaskT DRAMWriteMask,
	output logic    DRAMWriteDataValid,
	input  logic    DRAMWriteDataReady
);

	// ----------------------------------------
	// Internal wires
	// ----------------------------------------

	// Initializer
	ddrAddrT initCommandAddress;
	logic    initCommandValid;
	logic    initCommandReady;
	ddrDataT initWriteData;
	ddrMaskT initWriteMask;
	logic    initWriteDataValid;
	logic    initWriteDataReady;
	logic    initDone;

	// Address generator
	ddrAddrT genCommandAddress;
	ddrCmdT  genCommand;
	logic    genCommandValid;
	logic    genCommandReady;
	logic    normal;

	dramInitializer dramInit (
		.Clock(Clock),
		.rstN(rstN),
		.InitCommandAddress(initCommandAddress),
		.InitCommandValid(initCommandValid),
		.InitCommandReady(initCommandReady),
		.InitWriteData(initWriteData),
		.InitWriteMask(initWriteMask),
		.InitWriteDataValid(initWriteDataValid),
		.InitWriteDataReady(initWriteDataReady),
		.InitDone(initDone)
	);

	pathAddrGen addrGen (
		.Clock(Clock),
		.rstN(rstN),
		.Normal(normal),
		.InCommand(InCommand),
		.InLeaf(InLeaf),
		.InCommandValid(InCommandValid),
		.InCommandReady(InCommandReady),
		.GenCommandAddress(genCommandAddress),
		.GenCommand(genCommand),
		.GenCommandValid(genCommandValid),
		.GenCommandReady(genCommandReady)
	);

	backendControl control (
		.Clock(Clock),
		.rstN(rstN),
		.InitDone(initDone),
		.Normal(normal),
		.InitCommandAddress(initCommandAddress),
		.InitCommandValid(initCommandValid),
		.InitCommandReady(initCommandReady),
		.InitWriteData(initWriteData),
		.InitWriteMask(initWriteMask),
		.InitWriteDataValid(initWriteDataValid),
		.InitWriteDataReady(initWriteDataReady),
		.GenCommandAddress(genCommandAddress),
		.GenCommand(genCommand),
		.GenCommandValid(genCommandValid),
		.GenCommandReady(genCommandReady),
		.LoadData(LoadData),
		.LoadValid(LoadValid),
		.LoadReady(LoadReady),
		.DRAMCommandAddress(DRAMCommandAddress),
		.DRAMCommand(DRAMCommand),
		.DRAMCommandValid(DRAMCommandValid),
		.DRAMCommandReady(DRAMCommandReady),
		.DRAMWriteData(DRAMWriteData),
		.DRAMWriteMask(DRAMWriteMask),
		.DRAMWriteDataValid(DRAMWriteDataValid),
		.DRAMWriteDataReady(DRAMWriteDataReady)
	);

endmodule

// ==== hw/dramInit/dramInitializer.sv ====
// ----------------------------------------
// DRAM initializer
// Zeroes every bucket word of the tree
// ----------------------------------------
`timescale 1ns/10ps

module dramInitializer import oramPkg::*; (
	input  logic    Clock,
	input  logic    rstN,

	// Command stream, always a write
	output ddrAddrT InitCommandAddress,
	output logic    InitCommandValid,
	input  logic    InitCommandReady,

	// Zero data stream
	output ddrDataT InitWriteData,
	output ddrMaskT InitWriteMask,
	output logic    InitWriteDataValid,
	input  logic    InitWriteDataReady,

	output logic    InitDone
);

	// ----------------------------------------
	// Stream counters
	// ----------------------------------------

	// Index 0 is the command stream, index 1 the data stream
	logic [InitCntWidth-1:0] wordCount [2];
	logic [1:0]              streamValid;
	logic [1:0]              streamReady;
	logic [1:0]              streamDone;

	assign streamReady = {InitWriteDataReady, InitCommandReady};

	for (genvar s = 0; s < 2; s++) begin : genStream

		// Counter saturates at TreeWords
		assign streamDone[s] = (wordCount[s] == InitCntWidth'(TreeWords));

		always_ff @(posedge Clock or negedge rstN) begin
			if (!rstN) begin
				wordCount[s] <= '0;
				streamValid[s] <= 1'b0;
			end else if (!streamValid[s]) begin
				// Start once after reset
				// never again after the last word
				if (wordCount[s] == '0) begin
					streamValid[s] <= 1'b1;
				end
			end else if (streamReady[s]) begin
				wordCount[s] <= wordCount[s] + 1'b1;
				// Last word of the tree
				if (wordCount[s] == InitCntWidth'(TreeWords - 1)) begin
					streamValid[s] <= 1'b0;
				end
			end
		end

	end

	// ----------------------------------------
	// Outputs
	// ----------------------------------------

	// Address walks 0 .. TreeWords-1
	assign InitCommandAddress = ddrAddrT'(wordCount[0]);
	assign InitCommandValid = streamValid[0];

	// Empty tree is all zero, nothing masked
	assign InitWriteData = '0;
	assign InitWriteMask = '0;
	assign InitWriteDataValid = streamValid[1];

	// Both counters stay saturated, so this holds
	assign InitDone = &streamDone;

endmodule

// ==== list.f ====
+incdir+tb
common/oramPkg.sv
hw/dramInit/dramInitializer.sv
hw/addrGen/pathAddrGen.sv
hw/backend/backendControl.sv
hw/backend/pathOramBackend.sv
tb/tbPathOramBackend.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the backend testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps \
	-f list.f --top-module tbPathOramBackend -o simPathOram

# A failing run exits nonzero, the log decides
./obj_dir/simPathOram > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== tb/dramResponder.svh ====
// ----------------------------------------
// DRAM responder for the backend testbench
// Random back-pressure, transfer recording
// ----------------------------------------
`ifndef dramResponderSvh
`define dramResponderSvh

// ----------------------------------------
// Recorded transfers
// ----------------------------------------

// Initialization phase, before the first InCommandReady
ddrAddrT initAddrQ[$];
ddrCmdT  initCodeQ[$];
ddrDataT initDataQ[$];
ddrMaskT initMaskQ[$];

// Normal phase, path traffic
ddrAddrT pathAddrQ[$];
ddrCmdT  pathCodeQ[$];
ddrDataT pathDataQ[$];
ddrMaskT pathMaskQ[$];

// New ready values, driven on the falling edge
task automatic applyBackPressure();
	// Command port ready about 3 cycles in 4
	DRAMCommandReady = ($random(seed) & 3) != 0;
	// Data port ready about every other cycle
	DRAMWriteDataReady = ($random(seed) & 1) != 0;
endtask

// Valid and ready are stable until the next rising edge,
// so a match here is a transfer on that edge
task automatic recordTransfers();
	if (DRAMCommandValid && DRAMCommandReady) begin
		if (normalSeen) begin
			pathAddrQ.push_back(DRAMCommandAddress);
			pathCodeQ.push_back(DRAMCommand);
		end else begin
			initAddrQ.push_back(DRAMCommandAddress);
			initCodeQ.push_back(DRAMCommand);
		end
	end
	// Write data, paired with write commands by order only
	if (DRAMWriteDataValid && DRAMWriteDataReady) begin
		if (normalSeen) begin
			pathDataQ.push_back(DRAMWriteData);
			pathMaskQ.push_back(DRAMWriteMask);
		end else begin
			initDataQ.push_back(DRAMWriteData);
			initMaskQ.push_back(DRAMWriteMask);
		end
	end
endtask

`endif

// ==== tb/tbPathOramBackend.sv ====
// ----------------------------------------
// Testbench for the Path ORAM backend
// Random paths against a path address model
// ----------------------------------------
`timescale 1ns/10ps

module tbPathOramBackend import oramPkg::*; ();

	localparam int NumReadPaths = 40;
	localparam int NumWritePaths = 20;
	localparam int WaitLimit = 2000;

	logic    Clock;
	logic    rstN;
	beCmdT   InCommand;
	leafT    InLeaf;
	logic    InCommandValid;
	logic    InCommandReady;
	ddrDataT LoadData;
	logic    LoadValid;
	logic    LoadReady;
	ddrAddrT DRAMCommandAddress;
	ddrCmdT  DRAMCommand;
	logic    DRAMCommandValid;
	logic    DRAMCommandReady = 1'b0;
	ddrDataT DRAMReadData = '0;
	logic    DRAMReadDataValid = 1'b0;
	ddrDataT DRAMWriteData;
	ddrMaskT DRAMWriteMask;
	logic    DRAMWriteDataValid;
	logic    DRAMWriteDataReady = 1'b0;

	integer  seed = 32'hd063081e;
	bit      normalSeen = 1'b0;
	int      acceptedCount = 0;

	// Model expectations
	ddrAddrT expAddrQ[$];
	ddrCmdT  expCodeQ[$];
	ddrDataT expDataQ[$];

	`include "dramResponder.svh"

	pathOramBackend DUT (.*);

	initial Clock = 1'b0;
	always #50 Clock = ~Clock;

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	task automatic stopRun();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s: expected %0h, actual %0h", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic timeoutRun(input string what);
		$display("Timeout: %s", what);
		stopRun();
	endtask

	// Whole tree zeroed in address order
	task automatic checkInitWrites();
		int i;
		checkValue("init command count", 64'(TreeWords), 64'(initAddrQ.size()));
		checkValue("init data count", 64'(TreeWords), 64'(initDataQ.size()));
		for (i = 0; i < TreeWords; i++) begin
			checkValue($sformatf("init address %0d", i), 64'(i), 64'(initAddrQ[i]));
			checkValue($sformatf("init code %0d", i), 64'(DdrCmdWrite), 64'(initCodeQ[i]));
			checkValue($sformatf("init data %0d", i), 64'(0), 64'(initDataQ[i]));
			checkValue($sformatf("init mask %0d", i), 64'(0), 64'(initMaskQ[i]));
		end
	endtask

	// Frontend ports stay closed until the first InCommandReady
	task automatic checkInitPhase();
		if (!rstN) begin
			checkValue("command ready in reset", 64'(0), 64'(InCommandReady));
		end
		if (!normalSeen) begin
			if (InCommandReady) begin
				normalSeen = 1'b1;
				checkInitWrites();
			end else begin
				checkValue("load ready during init", 64'(0), 64'(LoadReady));
			end
		end
	endtask

	// Falling edge drive, sample 10 ns later
	always @(negedge Clock) begin
		applyBackPressure();
		#10;
		checkInitPhase();
		recordTransfers();
	end

	// ----------------------------------------
	// Path model and frontend
	// ----------------------------------------

	// Walk the heap from the root bucket
	// Leaf bits pick left or right child from the MSB down
	function automatic void pushPathModel(input beCmdT cmd, input leafT leaf);
		int level;
		int word;
		int bucket;
		bucket = 0;
		for (level = 0; level < NumLevels; level++) begin
			// Children of bucket b are 2b+1 and 2b+2
			if (level > 0) begin
				bucket = 2 * bucket + 1 + ((int'(leaf) >> (OramL - level)) & 1);
			end
			for (word = 0; word < BucketBursts; word++) begin
				expAddrQ.push_back(ddrAddrT'(bucket * BucketBursts + word));
				expCodeQ.push_back((cmd == BeCmdWritePath) ? DdrCmdWrite : DdrCmdRead);
			end
		end
	endfunction

	task automatic sendCommand(input beCmdT cmd, input leafT leaf);
		int waited;
		waited = 0;
		@(negedge Clock);
		InCommand = cmd;
		InLeaf = leaf;
		InCommandValid = 1'b1;
		#10;
		while (!InCommandReady) begin
			waited++;
			if (waited > WaitLimit) timeoutRun("frontend command was never accepted");
			@(negedge Clock);
			#10;
		end
		// Accepted on the coming rising edge
		pushPathModel(cmd, leaf);
		acceptedCount++;
		@(negedge Clock);
		InCommandValid = 1'b0;
	endtask

	// PathWords random words on the Load stream
	task automatic sendLoadWords();
		int i;
		int waited;
		for (i = 0; i < PathWords; i++) begin
			waited = 0;
			@(negedge Clock);
			LoadData = {$random(seed), $random(seed)};
			LoadValid = 1'b1;
			#10;
			while (!LoadReady) begin
				waited++;
				if (waited > WaitLimit) timeoutRun("load word was never accepted");
				@(negedge Clock);
				#10;
			end
			expDataQ.push_back(LoadData);
		end
		@(negedge Clock);
		LoadValid = 1'b0;
	endtask

	task automatic waitForNormal();
		int waited;
		waited = 0;
		while (!normalSeen) begin
			waited++;
			if (waited > WaitLimit) timeoutRun("initialization never finished");
			@(negedge Clock);
		end
	endtask

	task automatic waitForDrain();
		int waited;
		waited = 0;
		while (pathAddrQ.size() < expAddrQ.size() || pathDataQ.size() < expDataQ.size()) begin
			waited++;
			if (waited > WaitLimit) timeoutRun("DRAM traffic stopped before the last path");
			@(negedge Clock);
		end
	endtask

	task automatic checkResults();
		int i;
		// Lost or duplicated commands show up in the counts
		checkValue("path command count", 64'(PathWords * acceptedCount),
			64'(pathAddrQ.size()));
		checkValue("path data count", 64'(expDataQ.size()), 64'(pathDataQ.size()));
		for (i = 0; i < expAddrQ.size(); i++) begin
			checkValue($sformatf("path address %0d", i), 64'(expAddrQ[i]), 64'(pathAddrQ[i]));
			checkValue($sformatf("path code %0d", i), 64'(expCodeQ[i]), 64'(pathCodeQ[i]));
		end
		for (i = 0; i < expDataQ.size(); i++) begin
			checkValue($sformatf("path data %0d", i), expDataQ[i], pathDataQ[i]);
			checkValue($sformatf("path mask %0d", i), 64'(0), 64'(pathMaskQ[i]));
		end
	endtask

	initial begin
		int n;
		rstN = 1'b0;
		InCommand = BeCmdReadPath;
		InLeaf = '0;
		InCommandValid = 1'b0;
		LoadData = '0;
		LoadValid = 1'b0;
		repeat (10) @(negedge Clock);
		rstN = 1'b1;
		waitForNormal();
		// Read paths first, then write paths with their data
		for (n = 0; n < NumReadPaths; n++) begin
			sendCommand(BeCmdReadPath, leafT'($random(seed)));
		end
		for (n = 0; n < NumWritePaths; n++) begin
			fork
				sendCommand(BeCmdWritePath, leafT'($random(seed)));
				sendLoadWords();
			join
		end
		waitForDrain();
		// Settle, so that late extra transfers are counted too
		repeat (20) @(negedge Clock);
		checkResults();
		$display("Result: PASSED");
		$finish;
	end

endmodule
